// File: addrTranslator.sv
`timescale 1ns/1ps

module addrTranslator (
    input  logic                clk,
    input  logic                reset,
    input  logic                stallT,
    input  logic                flushT,
    input  mmuPkg::transReqT    req,
    input  mmuPkg::modeCsrT     mode,
    input  logic                tlbHit,
    input  mmuPkg::tlbEntryT    tlbEntry,
    output mmuPkg::transRespT   resp
);
    import mmuPkg::*;

    logic [1:0] plv;
    logic [VaLen-1:0] shiftedVa;
    logic oddHalf;
    pageAttrT page;
    logic [PaLen-1:0] lowMask;
    logic [PaLen-1:0] mappedPaddr;
    logic fault;
    transRespT respNext;

    function automatic logic dmwHit(dmwT win, logic [1:0] curPlv, logic [VaLen-1:0] va);
        logic plvOk;
        plvOk = (win.plv0 && curPlv == 2'd0) || (win.plv3 && curPlv == 2'd3);
        return plvOk && (win.vseg == va[VaLen-1:VaLen-3]);
    endfunction

    assign plv = mode.crmd.plv;

    // bit ps of vaddr picks the half of the pair
    assign shiftedVa = req.vaddr >> tlbEntry.ps;
    assign oddHalf = shiftedVa[0];
    assign page = oddHalf ? tlbEntry.odd : tlbEntry.even;

    assign lowMask = ~({PaLen{1'b1}} << tlbEntry.ps);
    assign mappedPaddr = ({page.ppn, {PageOffsetBits{1'b0}}} & ~lowMask)
                       | (req.vaddr & lowMask);

    always_comb
    begin
        respNext = '0;
        respNext.paddrValid = req.valid;
        fault = 1'b0;
        if (mode.crmd.da && !mode.crmd.pg)
        begin
            respNext.paddr = req.vaddr;
            respNext.memType = (req.opType == OpFetch) ? mode.crmd.datf : mode.crmd.datm;
        end
        else if (dmwHit(mode.dmw0, plv, req.vaddr))
        begin
            respNext.paddr = {mode.dmw0.pseg, req.vaddr[VaLen-4:0]};
            respNext.memType = mode.dmw0.mat;
        end
        else if (dmwHit(mode.dmw1, plv, req.vaddr))
        begin
            respNext.paddr = {mode.dmw1.pseg, req.vaddr[VaLen-4:0]};
            respNext.memType = mode.dmw1.mat;
        end
        else if (plv != 2'd0 && req.vaddr[VaLen-1])
        begin
            fault = 1'b1; // user touching the upper half
            respNext.excpArg.subcode = (req.opType == OpFetch) ? SubAdef : SubAdem;
            respNext.excpArg.code = ExcpAde;
        end
        else if (!tlbHit)
        begin
            fault = 1'b1;
            respNext.excpArg.code = ExcpTlbr;
        end
        else if (!page.valid)
        begin
            fault = 1'b1;
            if (req.opType == OpFetch)
                respNext.excpArg.code = ExcpPif;
            else if (req.opType == OpLoad)
                respNext.excpArg.code = ExcpPil;
            else
                respNext.excpArg.code = ExcpPis;
        end
        else if (plv > page.plv)
        begin
            fault = 1'b1;
            respNext.excpArg.code = ExcpPpi;
        end
        else if (req.opType == OpStore && !page.dirty)
        begin
            fault = 1'b1;
            respNext.excpArg.code = ExcpPme;
        end
        else
        begin
            respNext.paddr = mappedPaddr;
            respNext.memType = page.mat;
        end

        if (fault)
        begin
            respNext.paddrValid = 1'b0;
            respNext.excpArg.valid = req.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || flushT) // flush beats stall
            resp <= '0;
        else if (!stallT)
            resp <= respNext;
    end

    paddrOrExcp: assert property (
        @(posedge clk) disable iff (reset)
        !(resp.paddrValid && resp.excpArg.valid)
    ) else $error("addrTranslator paddr and exception both valid");

endmodule

// File: mmu.f
mmuPkg.sv
tlbArray.sv
tlbMatch.sv
tlbManager.sv
addrTranslator.sv
mmu.sv
mmuTb.sv

// File: mmu.sv
`timescale 1ns/1ps

module mmu #(
    parameter int TlbIndexWidth = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  mmuPkg::mgmtOpE      mgmtOp,
    input  mmuPkg::csrImageT    csrIn,
    input  mmuPkg::modeCsrT     mode,
    input  logic                stallW,
    input  logic                flushW,
    input  mmuPkg::transReqT    req,
    input  logic                stallT,
    input  logic                flushT,
    output mmuPkg::csrImageT    csrOut,
    output mmuPkg::transRespT   resp
);
    import mmuPkg::*;

    localparam int NumEntries = 1 << TlbIndexWidth;

    tlbEntryT [NumEntries-1:0] entries;
    tlbEntryT wrEntry;
    tlbEntryT mgrRdEntry;
    tlbEntryT lookupEntry;
    logic wrEn;
    logic searchHit;
    logic lookupHit;
    logic [TlbIndexWidth-1:0] wrIdx;
    logic [TlbIndexWidth-1:0] mgrRdIdx;
    logic [TlbIndexWidth-1:0] searchIdx;
    logic [TlbIndexWidth-1:0] lookupIdx;

    tlbArray #(.TlbIndexWidth(TlbIndexWidth)) tlbArray (
        .clk(clk),
        .reset(reset),
        .wrEn(wrEn),
        .wrIdx(wrIdx),
        .wrEntry(wrEntry),
        .rdIdxA(mgrRdIdx),
        .rdIdxB(lookupIdx),
        .rdEntryA(mgrRdEntry),
        .rdEntryB(lookupEntry),
        .entries(entries)
    );

    // TLBSRCH key is the EHI page
    tlbMatch #(.TlbIndexWidth(TlbIndexWidth)) searchMatch (
        .entries(entries),
        .vaddr(csrIn.tlbEhi),
        .asid(csrIn.asid),
        .hit(searchHit),
        .idx(searchIdx)
    );

    tlbMatch #(.TlbIndexWidth(TlbIndexWidth)) lookupMatch (
        .entries(entries),
        .vaddr(req.vaddr),
        .asid(csrIn.asid),
        .hit(lookupHit),
        .idx(lookupIdx)
    );

    tlbManager #(.TlbIndexWidth(TlbIndexWidth)) tlbManager (
        .clk(clk),
        .reset(reset),
        .stallW(stallW),
        .flushW(flushW),
        .mgmtOp(mgmtOp),
        .csrIn(csrIn),
        .searchHit(searchHit),
        .searchIdx(searchIdx),
        .rdEntry(mgrRdEntry),
        .rdIdx(mgrRdIdx),
        .wrEn(wrEn),
        .wrIdx(wrIdx),
        .wrEntry(wrEntry),
        .csrOut(csrOut)
    );

    addrTranslator addrTranslator (
        .clk(clk),
        .reset(reset),
        .stallT(stallT),
        .flushT(flushT),
        .req(req),
        .mode(mode),
        .tlbHit(lookupHit),
        .tlbEntry(lookupEntry),
        .resp(resp)
    );

endmodule

// File: mmuPkg.sv
package mmuPkg;

    localparam int PaLen = 32;
    localparam int VaLen = 32;
    localparam int PageOffsetBits = 12;

    typedef logic [VaLen-PageOffsetBits-2:0] vppnT; // vaddr[31:13], one even/odd pair
    typedef logic [PaLen-PageOffsetBits-1:0] ppnT;
    typedef logic [9:0] asidT;

    typedef struct packed {
        ppnT        ppn;
        logic [1:0] plv;
        logic [1:0] mat;
        logic       dirty;
        logic       valid;
    } pageAttrT;

    typedef struct packed {
        logic       exist;
        logic       isGlobal;
        asidT       asid;
        logic [5:0] ps;
        vppnT       vppn;
        pageAttrT   odd;
        pageAttrT   even;
    } tlbEntryT;

    typedef enum logic [2:0] {
        MgmtNone,
        MgmtSearch,
        MgmtRead,
        MgmtWrite,
        MgmtFill
    } mgmtOpE;

    typedef struct packed {
        logic [31:0] tlbIdx;  // [31] NE, [29:24] PS, low bits index
        logic [31:0] tlbEhi;
        logic [31:0] tlbElo0;
        logic [31:0] tlbElo1;
        asidT        asid;
    } csrImageT;

    // laid out as the CRMD register bits, plv at bit 0
    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmdT;

    typedef struct packed {
        logic [2:0]  vseg;
        logic        resvd28;
        logic [2:0]  pseg;
        logic [18:0] resvd24To6;
        logic [1:0]  mat;
        logic        plv3;
        logic [1:0]  resvd2To1;
        logic        plv0;
    } dmwT;

    typedef struct packed {
        crmdT crmd;
        dmwT  dmw0;
        dmwT  dmw1;
    } modeCsrT;

    typedef enum logic [1:0] {
        OpFetch = 2'd0,
        OpLoad  = 2'd1,
        OpStore = 2'd2
    } opTypeE;

    typedef struct packed {
        logic             valid;
        opTypeE           opType;
        logic [VaLen-1:0] vaddr;
    } transReqT;

    typedef enum logic [5:0] {
        ExcpPil  = 6'h01,
        ExcpPis  = 6'h02,
        ExcpPif  = 6'h03,
        ExcpPme  = 6'h04,
        ExcpPpi  = 6'h07,
        ExcpAde  = 6'h08,
        ExcpTlbr = 6'h3f
    } excpCodeE;

    localparam logic [8:0] SubAdef = 9'h000;
    localparam logic [8:0] SubAdem = 9'h001;

    typedef struct packed {
        logic       valid;
        logic [8:0] subcode;
        excpCodeE   code;
    } excpArgT;

    typedef struct packed {
        logic             paddrValid;
        logic [PaLen-1:0] paddr;
        excpArgT          excpArg;
        logic [1:0]       memType;
    } transRespT;

endpackage

// File: mmuTb.sv
`timescale 1ns/1ps

module mmuTb;
    import mmuPkg::*;

    localparam int TlbIndexWidth = 5;
    localparam int NumEntries = 1 << TlbIndexWidth;

    // testbench copy of a written entry, elo words as the CSR format
    typedef struct packed {
        logic        exist;
        logic        isGlobal;
        asidT        asid;
        logic [5:0]  ps;
        logic [31:0] ehi;
        logic [31:0] elo0;
        logic [31:0] elo1;
    } modelEntryT;

    logic clk;
    logic reset;
    mgmtOpE mgmtOp;
    csrImageT csrIn;
    modeCsrT mode;
    logic stallW;
    logic flushW;
    transReqT req;
    logic stallT;
    logic flushT;
    csrImageT csrOut;
    transRespT resp;

    modelEntryT model [NumEntries];
    int errorCount;
    int checkCount;

    mmu #(.TlbIndexWidth(TlbIndexWidth)) dut (
        .clk(clk),
        .reset(reset),
        .mgmtOp(mgmtOp),
        .csrIn(csrIn),
        .mode(mode),
        .stallW(stallW),
        .flushW(flushW),
        .req(req),
        .stallT(stallT),
        .flushT(flushT),
        .csrOut(csrOut),
        .resp(resp)
    );

    always #2 clk = ~clk;

    task automatic checkValue(string name, logic [159:0] got, logic [159:0] exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] eloWord(logic [19:0] ppn, logic g, logic [1:0] mat,
            logic [1:0] plv, logic d, logic v);
        return {4'b0, ppn, 1'b0, g, mat, plv, d, v};
    endfunction

    // highest matching index, -1 on a miss
    function automatic int modelFind(logic [31:0] va, asidT asid);
        int found;
        found = -1;
        for (int i = 0; i < NumEntries; i++)
        begin
            if (model[i].exist && (model[i].isGlobal || model[i].asid == asid)
                && (va >> (model[i].ps + 1)) == (model[i].ehi >> (model[i].ps + 1)))
                found = i;
        end
        return found;
    endfunction

    function automatic logic windowHit(dmwT w, logic [1:0] plv, logic [31:0] va);
        return ((plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3)) && w.vseg == va[31:29];
    endfunction

    function automatic transRespT expectResp(transReqT r, modeCsrT m, asidT asid);
        transRespT e;
        int hitIdx;
        logic [5:0] ps;
        logic [31:0] elo;
        logic [31:0] mask;
        e = '0;
        e.paddrValid = r.valid;
        if (m.crmd.da && !m.crmd.pg)
        begin
            e.paddr = r.vaddr;
            e.memType = (r.opType == OpFetch) ? m.crmd.datf : m.crmd.datm;
            return e;
        end
        if (windowHit(m.dmw0, m.crmd.plv, r.vaddr) || windowHit(m.dmw1, m.crmd.plv, r.vaddr))
        begin
            e.paddr[31:29] = windowHit(m.dmw0, m.crmd.plv, r.vaddr) ? m.dmw0.pseg : m.dmw1.pseg;
            e.paddr[28:0] = r.vaddr[28:0];
            e.memType = windowHit(m.dmw0, m.crmd.plv, r.vaddr) ? m.dmw0.mat : m.dmw1.mat;
            return e;
        end
        e.paddrValid = 1'b0; // every path below but the last is a fault
        e.excpArg.valid = r.valid;
        hitIdx = modelFind(r.vaddr, asid);
        ps = (hitIdx < 0) ? 6'd12 : model[hitIdx].ps;
        elo = (hitIdx < 0) ? 32'b0 : (r.vaddr[ps] ? model[hitIdx].elo1 : model[hitIdx].elo0);
        if (m.crmd.plv != 2'd0 && r.vaddr[31])
        begin
            e.excpArg.subcode = (r.opType == OpFetch) ? 9'd0 : 9'd1;
            e.excpArg.code = ExcpAde;
        end
        else if (hitIdx < 0)
            e.excpArg.code = ExcpTlbr;
        else if (!elo[0])
            e.excpArg.code = (r.opType == OpFetch) ? ExcpPif
                           : ((r.opType == OpLoad) ? ExcpPil : ExcpPis);
        else if (m.crmd.plv > elo[3:2])
            e.excpArg.code = ExcpPpi;
        else if (r.opType == OpStore && !elo[1])
            e.excpArg.code = ExcpPme;
        else
        begin
            mask = (32'd1 << ps) - 32'd1;
            e.excpArg = '0;
            e.paddrValid = r.valid;
            e.paddr = ({elo[27:8], 12'b0} & ~mask) | (r.vaddr & mask);
            e.memType = elo[5:4];
        end
        return e;
    endfunction

    // every task below starts and ends on a falling edge
    task automatic writeEntry(mgmtOpE op, int idx, logic [31:0] ehi, logic [5:0] ps,
            asidT asid, logic [31:0] elo0, logic [31:0] elo1, logic ne, logic flush);
        logic g;
        g = elo0[6] & elo1[6];
        mgmtOp = op;
        flushW = flush;
        csrIn = '0;
        csrIn.tlbIdx = {ne, 1'b0, ps, 24'(idx)};
        csrIn.tlbEhi = ehi;
        csrIn.tlbElo0 = elo0;
        csrIn.tlbElo1 = elo1;
        csrIn.asid = asid;
        @(negedge clk);
        mgmtOp = MgmtNone;
        flushW = 1'b0;
        if (flush)
            checkValue("csrOut after flushW", 160'(csrOut), 160'(0));
        else
        begin
            model[idx].exist = !ne;
            model[idx].isGlobal = g;
            model[idx].asid = asid;
            model[idx].ps = ps;
            model[idx].ehi = {ehi[31:13], 13'b0};
            model[idx].elo0 = {4'b0, elo0[27:8], 1'b0, g, elo0[5:0]};
            model[idx].elo1 = {4'b0, elo1[27:8], 1'b0, g, elo1[5:0]};
        end
    endtask

    task automatic search(logic [31:0] ehi, asidT asid);
        csrImageT exp;
        int idx;
        csrIn = '0;
        csrIn.tlbEhi = ehi;
        csrIn.asid = asid;
        mgmtOp = MgmtSearch;
        idx = modelFind(ehi, asid);
        exp = csrIn;
        exp.tlbIdx = (idx < 0) ? 32'h8000_0000 : 32'(idx);
        @(negedge clk);
        checkValue("csrOut search", 160'(csrOut), 160'(exp));
        mgmtOp = MgmtNone;
    endtask

    task automatic readEntry(int idx);
        csrImageT exp;
        csrIn = '0;
        csrIn.tlbIdx = 32'(idx);
        mgmtOp = MgmtRead;
        exp = '0;
        exp.tlbIdx = 32'h8000_0000;
        if (model[idx].exist)
        begin
            exp.tlbIdx = {2'b00, model[idx].ps, 24'(idx)};
            exp.tlbEhi = model[idx].ehi;
            exp.tlbElo0 = model[idx].elo0;
            exp.tlbElo1 = model[idx].elo1;
            exp.asid = model[idx].asid;
        end
        @(negedge clk);
        checkValue("csrOut read", 160'(csrOut), 160'(exp));
        mgmtOp = MgmtNone;
    endtask

    task automatic translate(opTypeE op, logic [31:0] va, asidT asid);
        transRespT exp;
        req.valid = 1'b1;
        req.opType = op;
        req.vaddr = va;
        csrIn.asid = asid;
        exp = expectResp(req, mode, asid);
        @(negedge clk);
        checkValue("resp.paddrValid", 160'(resp.paddrValid), 160'(exp.paddrValid));
        checkValue("resp.paddr", 160'(resp.paddr), 160'(exp.paddr));
        checkValue("resp.excpArg", 160'(resp.excpArg), 160'(exp.excpArg));
        checkValue("resp.memType", 160'(resp.memType), 160'(exp.memType));
    endtask

    task automatic translateFault(opTypeE op, logic [31:0] va, asidT asid, excpCodeE code,
            logic [8:0] sub);
        translate(op, va, asid);
        checkValue("resp.excpArg.code", 160'(resp.excpArg.code), 160'(code));
        checkValue("resp.excpArg.subcode", 160'(resp.excpArg.subcode), 160'(sub));
        checkValue("resp.paddrValid", 160'(resp.paddrValid), 160'(0));
    endtask

    task automatic resetState();
        checkValue("csrOut in reset", 160'(csrOut), 160'(0));
        checkValue("resp in reset", 160'(resp), 160'(0));
        reset = 1'b0;
        search(32'h1234_5000, 10'd1); // empty TLB, must miss
    endtask

    task automatic tlbManagement();
        writeEntry(MgmtWrite, 3, 32'h0040_0000, 6'd12, 10'd5,
            eloWord(20'h11111, 1'b0, 2'd1, 2'd3, 1'b1, 1'b1),
            eloWord(20'h22222, 1'b0, 2'd1, 2'd3, 1'b0, 1'b1), 1'b0, 1'b0);
        writeEntry(MgmtFill, 7, 32'h0100_0000, 6'd21, 10'd9,
            eloWord(20'h30000, 1'b1, 2'd2, 2'd3, 1'b1, 1'b1),
            eloWord(20'h40200, 1'b1, 2'd0, 2'd0, 1'b1, 1'b1), 1'b0, 1'b0);
        writeEntry(MgmtWrite, 10, 32'h0080_0000, 6'd12, 10'd5, // G only on one half
            eloWord(20'h55555, 1'b1, 2'd1, 2'd3, 1'b1, 1'b0),
            eloWord(20'h66666, 1'b0, 2'd3, 2'd0, 1'b1, 1'b1), 1'b0, 1'b0);
        writeEntry(MgmtFill, 12, 32'h0200_0000, 6'd12, 10'd5,
            eloWord(20'h77777, 1'b0, 2'd1, 2'd3, 1'b1, 1'b1),
            eloWord(20'h78888, 1'b0, 2'd1, 2'd3, 1'b1, 1'b1), 1'b1, 1'b0);
        search(32'h0040_0000, 10'd5);
        search(32'h0040_1abc, 10'd5); // odd half of the same pair
        search(32'h0130_0000, 10'd2); // global large page
        search(32'h0040_0000, 10'd6);
        search(32'h0080_0000, 10'd7);
        search(32'h0200_0000, 10'd5);
        readEntry(3);
        readEntry(7);
        readEntry(10);
        readEntry(12);
        readEntry(20);
    endtask

    task automatic directAndWindows();
        logic [31:0] offset;
        offset = $urandom();
        mode = '0;
        mode.crmd.da = 1'b1;
        mode.crmd.datf = 2'd1;
        mode.crmd.datm = 2'd2;
        translate(OpFetch, offset, 10'd5);
        translate(OpLoad, offset ^ 32'h8000_0000, 10'd5);
        translate(OpStore, $urandom(), 10'd5);
        mode = '0;
        mode.crmd.pg = 1'b1;
        mode.dmw0 = '{vseg: 3'd5, pseg: 3'd1, mat: 2'd1, plv0: 1'b1, default: '0};
        mode.dmw1 = '{vseg: 3'd0, pseg: 3'd2, mat: 2'd3, plv3: 1'b1, default: '0};
        translate(OpLoad, 32'hA000_0000 | (offset & 32'h1fff_ffff), 10'd5);
        translate(OpLoad, 32'h0040_0123, 10'd5); // dmw1 off at plv 0, so TLB
        mode.crmd.plv = 2'd3;
        translate(OpStore, 32'h0040_0123, 10'd5);
    endtask

    task automatic mappedTranslation();
        mode = '0;
        mode.crmd.pg = 1'b1;
        mode.crmd.plv = 2'd3;
        translate(OpLoad, 32'h0040_0000 | ($urandom() & 32'h0fff), 10'd5);
        translate(OpFetch, 32'h0040_1000 | ($urandom() & 32'h0fff), 10'd5);
        translate(OpLoad, 32'h0100_0000 | ($urandom() & 32'h1f_ffff), 10'd2);
        mode.crmd.plv = 2'd0;
        translate(OpStore, 32'h0120_0000 | ($urandom() & 32'h1f_ffff), 10'd2);
    endtask

    task automatic exceptionOrder();
        mode = '0;
        mode.crmd.pg = 1'b1;
        mode.crmd.plv = 2'd3;
        translateFault(OpFetch, 32'h9000_0000, 10'd5, ExcpAde, 9'd0);
        translateFault(OpStore, 32'hf000_1000, 10'd5, ExcpAde, 9'd1);
        translateFault(OpLoad, 32'h0500_0000, 10'd5, ExcpTlbr, 9'd0);
        translateFault(OpFetch, 32'h0080_0010, 10'd5, ExcpPif, 9'd0);
        translateFault(OpLoad, 32'h0080_0020, 10'd5, ExcpPil, 9'd0);
        translateFault(OpStore, 32'h0080_0030, 10'd5, ExcpPis, 9'd0);
        translateFault(OpLoad, 32'h0120_0000, 10'd2, ExcpPpi, 9'd0);
        translateFault(OpStore, 32'h0040_1000, 10'd5, ExcpPme, 9'd0);
    endtask

    task automatic stallAndFlush();
        transRespT held;
        translate(OpLoad, 32'h0040_0010, 10'd5);
        held = expectResp(req, mode, 10'd5);
        stallT = 1'b1;
        for (int k = 0; k < 3; k++)
        begin
            req.opType = OpStore;
            req.vaddr = $urandom();
            @(negedge clk);
            checkValue("resp under stallT", 160'(resp), 160'(held));
        end
        flushT = 1'b1; // still stalled, flush wins
        @(negedge clk);
        checkValue("resp after flushT", 160'(resp), 160'(0));
        flushT = 1'b0;
        stallT = 1'b0;
        writeEntry(MgmtWrite, 15, 32'h0300_0000, 6'd12, 10'd5,
            eloWord(20'h12345, 1'b0, 2'd1, 2'd3, 1'b1, 1'b1),
            eloWord(20'h12346, 1'b0, 2'd1, 2'd3, 1'b1, 1'b1), 1'b0, 1'b1);
        search(32'h0300_0000, 10'd5);
        readEntry(15);
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        mgmtOp = MgmtNone;
        csrIn = '0;
        mode = '0;
        stallW = 1'b0;
        flushW = 1'b0;
        req = '0;
        stallT = 1'b0;
        flushT = 1'b0;
        errorCount = 0;
        checkCount = 0;
        void'($urandom(31));
        for (int i = 0; i < NumEntries; i++)
            model[i] = '0;
        repeat (8) @(negedge clk);
        resetState();
        tlbManagement();
        directAndWindows();
        mappedTranslation();
        exceptionOrder();
        stallAndFlush();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial
    begin
        #20000;
        $display("simulation watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f mmu.f --top-module mmuTb -o mmuSim

./obj_dir/mmuSim | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation did not complete, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: tlbArray.sv
`timescale 1ns/1ps

module tlbArray #(
    parameter int TlbIndexWidth = 5
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        wrEn,
    input  logic [TlbIndexWidth-1:0]                    wrIdx,
    input  mmuPkg::tlbEntryT                            wrEntry,
    input  logic [TlbIndexWidth-1:0]                    rdIdxA,
    input  logic [TlbIndexWidth-1:0]                    rdIdxB,
    output mmuPkg::tlbEntryT                            rdEntryA,
    output mmuPkg::tlbEntryT                            rdEntryB,
    output mmuPkg::tlbEntryT [(1<<TlbIndexWidth)-1:0]   entries
);
    import mmuPkg::*;

    localparam int NumEntries = 1 << TlbIndexWidth;

    tlbEntryT store [NumEntries]; // payload, exist copy here is ignored
    logic [NumEntries-1:0] existQ;

    always_ff @(posedge clk)
    begin
        if (wrEn)
            store[wrIdx] <= wrEntry;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            existQ <= '0;
        else if (wrEn)
            existQ[wrIdx] <= wrEntry.exist;
    end

    for (genvar i = 0; i < NumEntries; i++)
    begin : genEntry
        always_comb
        begin
            entries[i] = store[i];
            entries[i].exist = existQ[i];
        end
    end

    // both read ports are async, same cycle as the index
    assign rdEntryA = entries[rdIdxA];
    assign rdEntryB = entries[rdIdxB];

    wrIdxInRange: assert property (
        @(posedge clk) disable iff (reset)
        wrEn |-> !$isunknown(wrIdx) && (int'(wrIdx) < NumEntries)
    ) else $error("tlbArray write index out of range");

endmodule

// File: tlbManager.sv
`timescale 1ns/1ps

module tlbManager #(
    parameter int TlbIndexWidth = 5
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stallW,
    input  logic                        flushW,
    input  mmuPkg::mgmtOpE              mgmtOp,
    input  mmuPkg::csrImageT            csrIn,
    input  logic                        searchHit,
    input  logic [TlbIndexWidth-1:0]    searchIdx,
    input  mmuPkg::tlbEntryT            rdEntry,
    output logic [TlbIndexWidth-1:0]    rdIdx,
    output logic                        wrEn,
    output logic [TlbIndexWidth-1:0]    wrIdx,
    output mmuPkg::tlbEntryT            wrEntry,
    output mmuPkg::csrImageT            csrOut
);
    import mmuPkg::*;

    localparam int NeBit = 31;

    csrImageT csrNext;

    function automatic pageAttrT eloToAttr(logic [31:0] elo);
        pageAttrT attr;
        attr.ppn = elo[PaLen-5:8];
        attr.mat = elo[5:4];
        attr.plv = elo[3:2];
        attr.dirty = elo[1];
        attr.valid = elo[0];
        return attr;
    endfunction

    function automatic logic [31:0] attrToElo(pageAttrT attr, logic isGlobal);
        return {4'b0, attr.ppn, 1'b0, isGlobal, attr.mat, attr.plv, attr.dirty, attr.valid};
    endfunction

    assign rdIdx = csrIn.tlbIdx[TlbIndexWidth-1:0];
    assign wrIdx = csrIn.tlbIdx[TlbIndexWidth-1:0];
    assign wrEn = (mgmtOp == MgmtWrite || mgmtOp == MgmtFill) && !stallW && !flushW;

    always_comb
    begin
        wrEntry.exist = !csrIn.tlbIdx[NeBit];
        wrEntry.isGlobal = csrIn.tlbElo0[6] & csrIn.tlbElo1[6]; // G only if both halves say so
        wrEntry.asid = csrIn.asid;
        wrEntry.ps = csrIn.tlbIdx[29:24];
        wrEntry.vppn = csrIn.tlbEhi[31:13];
        wrEntry.even = eloToAttr(csrIn.tlbElo0);
        wrEntry.odd = eloToAttr(csrIn.tlbElo1);
    end

    always_comb
    begin
        csrNext = csrIn;
        case (mgmtOp)
            MgmtSearch:
            begin
                csrNext.tlbIdx[NeBit] = !searchHit;
                if (searchHit)
                    csrNext.tlbIdx[TlbIndexWidth-1:0] = searchIdx;
            end
            MgmtRead:
            begin
                if (rdEntry.exist)
                begin
                    csrNext.tlbIdx[NeBit] = 1'b0;
                    csrNext.tlbIdx[29:24] = rdEntry.ps;
                    csrNext.tlbEhi = {rdEntry.vppn, 13'b0};
                    csrNext.tlbElo0 = attrToElo(rdEntry.even, rdEntry.isGlobal);
                    csrNext.tlbElo1 = attrToElo(rdEntry.odd, rdEntry.isGlobal);
                    csrNext.asid = rdEntry.asid;
                end
                else
                begin
                    csrNext = '0;
                    csrNext.tlbIdx[NeBit] = 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset || (flushW && !stallW))
            csrOut <= '0;
        else if (!stallW)
            csrOut <= csrNext;
    end

endmodule

// File: tlbMatch.sv
`timescale 1ns/1ps

module tlbMatch #(
    parameter int TlbIndexWidth = 5
) (
    input  mmuPkg::tlbEntryT [(1<<TlbIndexWidth)-1:0]   entries,
    input  logic [31:0]                                 vaddr,
    input  mmuPkg::asidT                                asid,
    output logic                                        hit,
    output logic [TlbIndexWidth-1:0]                    idx
);
    import mmuPkg::*;

    localparam int NumEntries = 1 << TlbIndexWidth;

    logic [NumEntries-1:0] matchVec;
    logic [VaLen-2:0] pageVa;

    assign pageVa = vaddr[VaLen-1:1]; // bit 0 of this is vaddr[1]

    for (genvar i = 0; i < NumEntries; i++)
    begin : genCompare
        logic [VaLen-2:0] entryVa;
        logic asidOk;

        assign entryVa = {entries[i].vppn, {PageOffsetBits{1'b0}}};
        assign asidOk = entries[i].isGlobal || (entries[i].asid == asid);
        // shift by ps drops everything below ps+1, so both halves hit
        assign matchVec[i] = entries[i].exist && asidOk
            && ((entryVa >> entries[i].ps) == (pageVa >> entries[i].ps));
    end

    assign hit = |matchVec;

    always_comb
    begin
        idx = '0;
        for (int i = 0; i < NumEntries; i++)
        begin
            if (matchVec[i])
                idx = TlbIndexWidth'(i); // highest wins
        end
    end

    // software must never leave two overlapping entries
    always_comb
    begin
        matchOneHot: assert ($onehot0(matchVec))
            else $error("tlbMatch multiple entries hit");
    end

endmodule
